//--- src/pacc_pkg.sv
package pacc_pkg;

  //////////////////////////////////////////////////////////////////////
  // Kyber arithmetic constants
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned kyber_q    = 3329;
  localparam int unsigned kyber_k    = 2;
  localparam int unsigned pair_count = 128;

  // Datapath widths
  localparam int unsigned coeff_w = 12;
  localparam int unsigned pair_w  = 7;
  localparam int unsigned prod_w  = 24;

  // Barrett multiplier floor(2^26 / q), 15 bits wide
  localparam int unsigned barrett_shift = 26;
  localparam int unsigned barrett_m     = 20158;
  localparam int unsigned barrett_m_w   = 15;
  localparam int unsigned quot_w        = prod_w + barrett_m_w - barrett_shift;

  // Register stages behind the sequencer output (basemul, accumulate)
  localparam int unsigned drain_stages = 2;
  localparam int unsigned drain_cnt_w  = 2;

  //////////////////////////////////////////////////////////////////////
  // Stream types
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [coeff_w-1:0] c0;
    logic [coeff_w-1:0] c1;
  } coeff_pair_t;

  // Memory address, vector index on top
  typedef struct packed {
    logic              poly;
    logic [pair_w-1:0] pair;
  } rd_req_t;

  // Sideband that follows each item down the pipe
  typedef struct packed {
    logic              valid;
    logic [pair_w-1:0] pair;
    logic              poly;
    logic              last;
  } tag_t;

  typedef struct packed {
    logic [prod_w-1:0]  a0b0;
    logic [prod_w-1:0]  a1b1;
    logic [prod_w-1:0]  a0b1;
    logic [prod_w-1:0]  a1b0;
    logic [coeff_w-1:0] zeta;
  } prod_t;

  typedef enum logic [1:0] {
    seq_idle,
    seq_fetch,
    seq_drain
  } seq_state_e;

  //////////////////////////////////////////////////////////////////////
  // Arithmetic helpers
  //////////////////////////////////////////////////////////////////////

  // Quotient estimate is at most one short, so one correction step
  function automatic logic [coeff_w-1:0] barrett_reduce(input logic [prod_w-1:0] x);
    logic [prod_w+barrett_m_w-1:0] xm;
    logic [quot_w-1:0]             t;
    logic [prod_w:0]               r;
    xm = x * barrett_m;
    t  = xm[prod_w+barrett_m_w-1:barrett_shift];
    r  = (prod_w + 1)'(x - t * kyber_q);
    return (r >= kyber_q) ? coeff_w'(r - kyber_q) : coeff_w'(r);
  endfunction

  // 17^(2*bitrev7(j)+1) mod q by square and multiply
  function automatic logic [coeff_w-1:0] zeta_of(input logic [pair_w-1:0] j);
    logic [pair_w:0] e;
    int unsigned     acc;
    int unsigned     base;
    e[0] = 1'b1;
    for (int i = 0; i < pair_w; i++) begin
      e[i+1] = j[pair_w-1-i];
    end
    acc  = 1;
    base = 17;
    for (int i = 0; i <= pair_w; i++) begin
      if (e[i]) begin
        acc = (acc * base) % kyber_q;
      end
      base = (base * base) % kyber_q;
    end
    return coeff_w'(acc);
  endfunction

endpackage

//--- src/pacc_sequencer.sv
`timescale 1ns/10ps

module pacc_sequencer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  i_start,
  input  pacc_pkg::coeff_pair_t i_rd_a,
  input  pacc_pkg::coeff_pair_t i_rd_b,
  output pacc_pkg::rd_req_t     o_rd_req,
  output pacc_pkg::tag_t        o_tag,
  output pacc_pkg::coeff_pair_t o_a,
  output pacc_pkg::coeff_pair_t o_b,
  output logic                  o_busy,
  output logic                  o_done
);

  pacc_pkg::seq_state_e                 state;
  pacc_pkg::tag_t                       mem_tag;
  logic [pacc_pkg::drain_cnt_w-1:0]     drain_cnt;
  logic                                 req_last;

  // Final address is pair 127 of vector 1
  assign req_last = o_rd_req.poly &&
                    (o_rd_req.pair == pacc_pkg::pair_w'(pacc_pkg::pair_count - 1));

  // Busy stretches over the done cycle
  assign o_busy = (state != pacc_pkg::seq_idle) || o_done;

  //////////////////////////////////////////////////////////////////////
  // FSM and read address walk
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= pacc_pkg::seq_idle;
      o_rd_req <= '0;
    end else begin
      case (state)
        pacc_pkg::seq_idle: begin
          // Start during the done cycle is dropped
          if (i_start && !o_done) begin
            state <= pacc_pkg::seq_fetch;
          end
        end
        pacc_pkg::seq_fetch: begin
          if (req_last) begin
            state    <= pacc_pkg::seq_drain;
            o_rd_req <= '0;
          end else if (o_rd_req.poly) begin
            // Vector 1 done, next pair
            o_rd_req.poly <= 1'b0;
            o_rd_req.pair <= o_rd_req.pair + 1'b1;
          end else begin
            o_rd_req.poly <= 1'b1;
          end
        end
        pacc_pkg::seq_drain: begin
          if (drain_cnt == pacc_pkg::drain_cnt_w'(1)) begin
            state <= pacc_pkg::seq_idle;
          end
        end
        default: state <= pacc_pkg::seq_idle;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Tag alignment and drain count
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mem_tag   <= '0;
      o_tag     <= '0;
      drain_cnt <= '0;
      o_done    <= 1'b0;
    end else begin
      // Same cycle as the memory read data
      mem_tag.valid <= (state == pacc_pkg::seq_fetch);
      mem_tag.pair  <= o_rd_req.pair;
      mem_tag.poly  <= o_rd_req.poly;
      mem_tag.last  <= (state == pacc_pkg::seq_fetch) && req_last;
      o_tag         <= mem_tag;
      // Count the last item through basemul and accumulate
      if (o_tag.valid && o_tag.last) begin
        drain_cnt <= pacc_pkg::drain_cnt_w'(pacc_pkg::drain_stages);
      end else if (drain_cnt != '0) begin
        drain_cnt <= drain_cnt - 1'b1;
      end
      o_done <= (drain_cnt == pacc_pkg::drain_cnt_w'(1));
    end
  end

  // Read data captured beside its tag
  always_ff @(posedge clk) begin
    o_a <= i_rd_a;
    o_b <= i_rd_b;
  end

endmodule

//--- src/pacc_basemul.sv
`timescale 1ns/10ps

module pacc_basemul (
  input  logic                  clk,
  input  logic                  rst_n,
  input  pacc_pkg::tag_t        i_tag,
  input  pacc_pkg::coeff_pair_t i_a,
  input  pacc_pkg::coeff_pair_t i_b,
  output pacc_pkg::tag_t        o_tag,
  output pacc_pkg::prod_t       o_prod
);

  // Constant zeta per pair index
  logic [pacc_pkg::coeff_w-1:0] zeta_rom [pacc_pkg::pair_count];

  for (genvar gj = 0; gj < pacc_pkg::pair_count; gj++) begin : g_zeta
    assign zeta_rom[gj] = pacc_pkg::zeta_of(pacc_pkg::pair_w'(gj));
  end

  //////////////////////////////////////////////////////////////////////
  // Product stage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_tag <= '0;
    end else begin
      o_tag <= i_tag;
    end
  end

  // Four raw 12x12 products, no reduction yet
  always_ff @(posedge clk) begin
    o_prod.a0b0 <= i_a.c0 * i_b.c0;
    o_prod.a1b1 <= i_a.c1 * i_b.c1;
    o_prod.a0b1 <= i_a.c0 * i_b.c1;
    o_prod.a1b0 <= i_a.c1 * i_b.c0;
    o_prod.zeta <= zeta_rom[i_tag.pair];
  end

endmodule

//--- src/pacc_accumulate.sv
`timescale 1ns/10ps

module pacc_accumulate (
  input  logic                         clk,
  input  logic                         rst_n,
  input  pacc_pkg::tag_t               i_tag,
  input  pacc_pkg::prod_t              i_prod,
  output logic                         o_wr_en,
  output logic [pacc_pkg::pair_w-1:0]  o_wr_addr,
  output pacc_pkg::coeff_pair_t        o_wr_data
);

  logic [pacc_pkg::coeff_w-1:0] a1b1_r;
  logic [pacc_pkg::prod_w-1:0]  zeta_prod;
  logic [pacc_pkg::coeff_w-1:0] zeta_term;
  logic [pacc_pkg::coeff_w-1:0] a1b0_r;
  pacc_pkg::coeff_pair_t        pair_res;
  pacc_pkg::coeff_pair_t        hold;

  // Sum of two reduced values, one subtract
  function automatic logic [pacc_pkg::coeff_w-1:0] mod_add(
    input logic [pacc_pkg::coeff_w-1:0] x,
    input logic [pacc_pkg::coeff_w-1:0] y
  );
    logic [pacc_pkg::coeff_w:0] s;
    s = x + y;
    if (s >= pacc_pkg::kyber_q) begin
      return pacc_pkg::coeff_w'(s - pacc_pkg::kyber_q);
    end
    return pacc_pkg::coeff_w'(s);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Basemul reduction
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // a1*b1*zeta, reduced before and after the zeta multiply
    a1b1_r    = pacc_pkg::barrett_reduce(i_prod.a1b1);
    zeta_prod = a1b1_r * i_prod.zeta;
    zeta_term = pacc_pkg::barrett_reduce(zeta_prod);
    // One raw product plus one reduced term stays below 2^24
    a1b0_r      = pacc_pkg::barrett_reduce(i_prod.a1b0);
    pair_res.c0 = pacc_pkg::barrett_reduce(i_prod.a0b0 + zeta_term);
    pair_res.c1 = pacc_pkg::barrett_reduce(i_prod.a0b1 + a1b0_r);
  end

  //////////////////////////////////////////////////////////////////////
  // Vector accumulation and write port
  //////////////////////////////////////////////////////////////////////

  // Write on every vector 1 item
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_wr_en <= 1'b0;
    end else begin
      o_wr_en <= i_tag.valid && i_tag.poly;
    end
  end

  always_ff @(posedge clk) begin
    // Vector 0 result waits here for its partner
    if (i_tag.valid && !i_tag.poly) begin
      hold <= pair_res;
    end
    if (i_tag.valid && i_tag.poly) begin
      o_wr_addr    <= i_tag.pair;
      o_wr_data.c0 <= mod_add(hold.c0, pair_res.c0);
      o_wr_data.c1 <= mod_add(hold.c1, pair_res.c1);
    end
  end

endmodule

//--- src/pacc_top.sv
`timescale 1ns/10ps

module pacc_top (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         i_start,
  input  pacc_pkg::coeff_pair_t        i_rd_a,
  input  pacc_pkg::coeff_pair_t        i_rd_b,
  output pacc_pkg::rd_req_t            o_rd_req,
  output logic                         o_busy,
  output logic                         o_wr_en,
  output logic [pacc_pkg::pair_w-1:0]  o_wr_addr,
  output pacc_pkg::coeff_pair_t        o_wr_data,
  output logic                         o_done
);

  // Sequencer to basemul
  pacc_pkg::tag_t        seq_tag;
  pacc_pkg::coeff_pair_t seq_a;
  pacc_pkg::coeff_pair_t seq_b;

  // Basemul to accumulate
  pacc_pkg::tag_t        bm_tag;
  pacc_pkg::prod_t       bm_prod;

  //////////////////////////////////////////////////////////////////////
  // Three stage pipe
  //////////////////////////////////////////////////////////////////////

  pacc_sequencer u_sequencer (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_start  (i_start),
    .i_rd_a   (i_rd_a),
    .i_rd_b   (i_rd_b),
    .o_rd_req (o_rd_req),
    .o_tag    (seq_tag),
    .o_a      (seq_a),
    .o_b      (seq_b),
    .o_busy   (o_busy),
    .o_done   (o_done)
  );

  pacc_basemul u_basemul (
    .clk    (clk),
    .rst_n  (rst_n),
    .i_tag  (seq_tag),
    .i_a    (seq_a),
    .i_b    (seq_b),
    .o_tag  (bm_tag),
    .o_prod (bm_prod)
  );

  pacc_accumulate u_accumulate (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_tag     (bm_tag),
    .i_prod    (bm_prod),
    .o_wr_en   (o_wr_en),
    .o_wr_addr (o_wr_addr),
    .o_wr_data (o_wr_data)
  );

endmodule

//--- verification/pacc_model.svh
`ifndef PACC_MODEL_SVH
`define PACC_MODEL_SVH

// Modular power by plain repeated multiply
function automatic int unsigned pow_mod(input int unsigned b, input int unsigned e);
  int unsigned acc;
  acc = 1;
  for (int unsigned i = 0; i < e; i++) begin
    acc = (acc * b) % pacc_pkg::kyber_q;
  end
  return acc;
endfunction

// zeta_j = 17^(2*bitrev7(j)+1) mod q
function automatic int unsigned zeta_ref(input int unsigned j);
  int unsigned rev;
  rev = 0;
  for (int i = 0; i < 7; i++) begin
    rev = (rev << 1) | ((j >> i) & 1);
  end
  return pow_mod(17, 2 * rev + 1);
endfunction

// Basemul from the formula in 64-bit arithmetic
function automatic pacc_pkg::coeff_pair_t basemul_ref(input pacc_pkg::coeff_pair_t a,
    input pacc_pkg::coeff_pair_t b, input longint unsigned z);
  pacc_pkg::coeff_pair_t r;
  r.c0 = 12'((64'(a.c0) * b.c0 + 64'(a.c1) * b.c1 * z) % pacc_pkg::kyber_q);
  r.c1 = 12'((64'(a.c0) * b.c1 + 64'(a.c1) * b.c0) % pacc_pkg::kyber_q);
  return r;
endfunction

// Rank 2 inner product for one pair index
function automatic pacc_pkg::coeff_pair_t inner_ref(input pacc_pkg::coeff_pair_t a0, b0,
    input pacc_pkg::coeff_pair_t a1, b1, input int unsigned j);
  pacc_pkg::coeff_pair_t p;
  pacc_pkg::coeff_pair_t s;
  p = basemul_ref(a0, b0, zeta_ref(j));
  s = basemul_ref(a1, b1, zeta_ref(j));
  p.c0 = 12'((32'(p.c0) + s.c0) % pacc_pkg::kyber_q);
  p.c1 = 12'((32'(p.c1) + s.c1) % pacc_pkg::kyber_q);
  return p;
endfunction

`endif

//--- verification/pacc_tb.sv
`timescale 1ns/10ps

module pacc_tb;

  logic                        clk;
  logic                        rst_n;
  logic                        i_start;
  pacc_pkg::coeff_pair_t       i_rd_a = '0;
  pacc_pkg::coeff_pair_t       i_rd_b = '0;
  pacc_pkg::rd_req_t           o_rd_req;
  logic                        o_busy;
  logic                        o_wr_en;
  logic [pacc_pkg::pair_w-1:0] o_wr_addr;
  pacc_pkg::coeff_pair_t       o_wr_data;
  logic                        o_done;

  // Vector memories indexed by {poly, pair}
  pacc_pkg::coeff_pair_t mem_a [256];
  pacc_pkg::coeff_pair_t mem_b [256];
  // Write capture per pair
  pacc_pkg::coeff_pair_t got [128];
  int    wr_hits [128];
  int    wr_total;
  int    done_total;
  int    next_addr;
  int    err_count;
  int    err_mark;
  int    pass_tests;
  int    fail_tests;
  int    snap;
  int    seed;
  bit    timed_out;
  string test_name;

  `include "pacc_model.svh"

  pacc_top u_pacc_top (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Synchronous read with data one cycle after the address
  always @(posedge clk) begin
    i_rd_a <= #1 mem_a[o_rd_req];
    i_rd_b <= #1 mem_b[o_rd_req];
  end

  function automatic void report_failure(input string msg);
    err_count++;
    $display("%s: %s", test_name, msg);
  endfunction

  function automatic void report_value(input string what, input logic [31:0] exp_v,
      input logic [31:0] act_v);
    err_count++;
    $display("** Error %s %s expected %0h actual %0h", test_name, what, exp_v, act_v);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Write monitor and protocol checks
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (rst_n && o_wr_en) begin
      // Ascending pair order
      assert (int'(o_wr_addr) == next_addr) else
        report_value("write address", next_addr, o_wr_addr);
      got[o_wr_addr] = o_wr_data;
      wr_hits[o_wr_addr]++;
      wr_total++;
      next_addr++;
    end
    if (rst_n && o_done) begin
      done_total++;
    end
  end

  a_wr_busy: assert property (@(posedge clk) disable iff (!rst_n) o_wr_en |-> o_busy)
    else report_failure("write strobe while busy was low");
  a_done_last: assert property (@(posedge clk) disable iff (!rst_n)
    o_done |-> $past(o_wr_en) && $past(o_wr_addr) == 7'd127)
    else report_failure("done not one cycle after the pair 127 write");
  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) o_done |-> !$past(o_done))
    else report_failure("done held longer than one cycle");
  a_busy_rise: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(o_busy) |-> $past(i_start)) else report_failure("busy rose without a start");
  a_busy_fall: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(o_busy) |-> $past(o_done)) else report_failure("busy fell without done");

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [11:0] rand_coeff();
    int unsigned r;
    r = $random(seed);
    return 12'(r % pacc_pkg::kyber_q);
  endfunction

  task automatic fill_random();
    for (int i = 0; i < 256; i++) begin
      mem_a[i] = {rand_coeff(), rand_coeff()};
      mem_b[i] = {rand_coeff(), rand_coeff()};
    end
  endtask

  task automatic fill_const(input logic [11:0] val);
    for (int i = 0; i < 256; i++) begin
      mem_a[i] = {val, val};
      mem_b[i] = {val, val};
    end
  endtask

  // Zero one vector of a
  task automatic clear_vector(input int poly);
    for (int j = 0; j < 128; j++) begin
      mem_a[poly * 128 + j] = '0;
    end
  endtask

  task automatic pulse_start();
    @(posedge clk);
    #1 i_start = 1'b1;
    @(posedge clk);
    #1 i_start = 1'b0;
  endtask

  task automatic start_run();
    next_addr  = 0;
    wr_total   = 0;
    done_total = 0;
    for (int j = 0; j < 128; j++) begin
      wr_hits[j] = 0;
    end
    pulse_start();
  endtask

  // Poll done at the falling edge and let the monitor catch up
  task automatic wait_done();
    int n;
    n = 0;
    while (!o_done && n < 1000 && !timed_out) begin
      @(negedge clk);
      n++;
    end
    if (!o_done && !timed_out) begin
      timed_out = 1'b1;
      report_failure("timed out waiting for done");
    end
    repeat (2) @(negedge clk);
  endtask

  // Mode 0 is the full sum, mode 1 vector 0 only and mode 2 vector 1 only
  task automatic check_results(input int mode);
    pacc_pkg::coeff_pair_t exp_p;
    assert (wr_total == 128 && done_total == 1) else
      report_failure($sformatf("%0d writes and %0d done pulses", wr_total, done_total));
    for (int j = 0; j < 128; j++) begin
      case (mode)
        1:       exp_p = basemul_ref(mem_a[j], mem_b[j], zeta_ref(j));
        2:       exp_p = basemul_ref(mem_a[128 + j], mem_b[128 + j], zeta_ref(j));
        default: exp_p = inner_ref(mem_a[j], mem_b[j], mem_a[128 + j], mem_b[128 + j], j);
      endcase
      assert (wr_hits[j] == 1) else
        report_failure($sformatf("pair %0d written %0d times", j, wr_hits[j]));
      assert (got[j] == exp_p) else
        report_value($sformatf("pair %0d", j), exp_p, got[j]);
      assert (got[j].c0 < pacc_pkg::kyber_q && got[j].c1 < pacc_pkg::kyber_q) else
        report_failure($sformatf("pair %0d not reduced below q", j));
    end
  endtask

  task automatic run_and_check(input int mode);
    start_run();
    wait_done();
    check_results(mode);
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    err_mark  = err_count;
  endtask

  task automatic end_test();
    if (err_count == err_mark) begin
      pass_tests++;
      $display("test %s: ok", test_name);
    end else begin
      fail_tests++;
      $display("test %s: FAILED with %0d errors", test_name, err_count - err_mark);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    seed       = 32'h870e727b;
    rst_n      = 1'b0;
    i_start    = 1'b0;
    err_count  = 0;
    pass_tests = 0;
    fail_tests = 0;
    timed_out  = 1'b0;
    test_name  = "reset";
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;

    begin_test("random_run");
    fill_random();
    run_and_check(0);
    end_test();

    begin_test("control");
    fill_random();
    start_run();
    @(negedge clk);
    assert (o_busy) else report_failure("busy not high after start");
    wait_done();
    assert (!o_busy) else report_failure("busy still high after done");
    check_results(0);
    end_test();

    begin_test("extreme_values");
    fill_const(12'd3328);
    run_and_check(0);
    end_test();

    begin_test("isolate_vec0");
    fill_random();
    clear_vector(1);
    run_and_check(1);
    end_test();

    begin_test("isolate_vec1");
    fill_random();
    clear_vector(0);
    run_and_check(2);
    end_test();

    // Second start lands in the middle of the fetch
    begin_test("restart_mid_run");
    fill_random();
    start_run();
    repeat (40) @(posedge clk);
    pulse_start();
    wait_done();
    check_results(0);
    end_test();

    begin_test("rerun_after_done");
    fill_random();
    run_and_check(0);
    end_test();

    begin_test("reset_mid_run");
    fill_random();
    start_run();
    repeat (60) @(posedge clk);
    #1 rst_n = 1'b0;
    @(posedge clk);
    @(negedge clk);
    assert (!o_wr_en && !o_done && !o_busy) else
      report_failure("outputs not cleared by reset");
    assert (o_rd_req == '0) else
      report_value("read address", 0, o_rd_req);
    snap = wr_total;
    @(posedge clk);
    #1 rst_n = 1'b1;
    repeat (300) @(negedge clk);
    assert (wr_total == snap && done_total == 0) else
      report_failure("activity after reset without a start");
    fill_random();
    run_and_check(0);
    end_test();

    $display("tests %0d, ok %0d, failing %0d, errors %0d",
             pass_tests + fail_tests, pass_tests, fail_tests, err_count);
    if (err_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- state_pacc.f
+incdir+verification
src/pacc_pkg.sv
src/pacc_sequencer.sv
src/pacc_basemul.sv
src/pacc_accumulate.sv
src/pacc_top.sv
verification/pacc_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and search the output for the pass line
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal --top-module pacc_tb -f state_pacc.f &&
  out="$(./obj_dir/Vpacc_tb)" &&
  printf '%s\n' "$out" &&
  printf '%s\n' "$out" | grep -qx 'sim passed' ||
  exit 1
